// ==== verilog/na_pkg.sv ====
// *****************************
// shared types and constants of the network adapter register side
// modules import it inside their body, ports use scoped names
// *****************************
`default_nettype none

package na_pkg;

   // system description, handed down from the top as a parameter
   typedef struct packed {
      logic [15:0]       num_tiles;
      logic [7:0]        cores_per_tile;
      logic [31:0]       gmem_size;       // global memory size in bytes
      logic [15:0]       gmem_tile;       // tile holding global memory
      logic [31:0]       lmem_size;
      logic              enable_mp_simple;
      logic              enable_dma;
      logic [6:0]        num_cts;         // at most 64
      logic [63:0][15:0] ct_list;         // tile ids of the compute tiles
   } na_config_t;

   // single tile, no compute tile list
   localparam na_config_t na_config_default = '{
      num_tiles:        16'd1,
      cores_per_tile:   8'd1,
      gmem_size:        32'd0,
      gmem_tile:        16'd0,
      lmem_size:        32'd0,
      enable_mp_simple: 1'b1,
      enable_dma:       1'b0,
      num_cts:          7'd0,
      ct_list:          '0
   };

   // wishbone classic request as seen by the slave
   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      logic [15:0] adr;
      logic [31:0] dat;
   } wb_req_t;

   // response, ack or err for one cycle
   typedef struct packed {
      logic        ack;
      logic        err;
      logic [31:0] dat;
   } wb_rsp_t;

   // region code from adr 15:12
   typedef enum logic [3:0] {
      region_conf = 4'd0,
      region_mp   = 4'd1
   } na_region_e;

   // config word indices, adr 11:2
   localparam logic [9:0] reg_tile_id      = 10'd0;
   localparam logic [9:0] reg_num_tiles    = 10'd1;
   localparam logic [9:0] reg_conf         = 10'd3;
   localparam logic [9:0] reg_core_base    = 10'd4;
   localparam logic [9:0] reg_domain_cores = 10'd6;
   localparam logic [9:0] reg_gmem_size    = 10'd7;
   localparam logic [9:0] reg_gmem_tile    = 10'd8;
   localparam logic [9:0] reg_lmem_size    = 10'd9;
   localparam logic [9:0] reg_num_cts      = 10'd10;
   localparam logic [9:0] reg_cdc_conf     = 10'h42;

   localparam int conf_bit_mp  = 0;   // feature flags in reg_conf
   localparam int conf_bit_dma = 1;

   // compute tile list at 0x200..0x27f, matched on adr 11:9
   localparam logic [15:0] ct_list_base = 16'h0200;

   // mailbox word indices
   localparam logic [9:0] mp_data   = 10'd0;
   localparam logic [9:0] mp_status = 10'd1;
   localparam int mp_stat_full_bit  = 8;   // outgoing queue full

   localparam logic [2:0] cdc_conf_default = 3'b000;

endpackage

`default_nettype wire

// ==== verilog/na_bus_decode.sv ====
// *****************************
// wishbone classic slave front end of the adapter registers
// picks the region, strobes one block per request and
// registers ack or err with the read word one cycle later
// *****************************
`timescale 1ns/100ps
`default_nettype none

module na_bus_decode (
   input  wire logic            clk,
   input  wire logic            rst,
   input  wire na_pkg::wb_req_t req,
   input  wire logic [31:0]     conf_dat,  // comb read word, config block
   input  wire logic [31:0]     mp_dat,    // comb read word, mailbox
   input  wire logic            mp_miss,   // mailbox cannot serve this access
   output na_pkg::wb_rsp_t      rsp,
   output logic                 sel_conf,
   output logic                 sel_mp,
   output na_pkg::wb_req_t      fwd
);
   import na_pkg::*;

   na_region_e  region;
   logic        take;      // request sampled at this edge
   logic        busy;      // served, waiting for stb to drop
   logic        hit_err;
   logic [31:0] rd_dat;
   logic        ack_q;
   logic        err_q;
   logic [31:0] dat_q;

   assign region = na_region_e'(req.adr[15:12]);
   assign take   = req.cyc && req.stb && !busy;

   // blocks see the raw request, only the strobe is qualified
   assign fwd = req;

   always_comb begin
      sel_conf = 1'b0;
      sel_mp   = 1'b0;
      hit_err  = 1'b1;   // unmapped unless a region claims it
      rd_dat   = '0;
      case (region)
         region_conf: begin
            sel_conf = take;
            hit_err  = 1'b0;   // config block takes every index
            rd_dat   = conf_dat;
         end
         region_mp: begin
            sel_mp  = take;
            hit_err = mp_miss;
            rd_dat  = mp_dat;
         end
         default: begin
            hit_err = 1'b1;
         end
      endcase
   end

   // one response per stb assertion
   always_ff @(posedge clk) begin
      if (rst) begin
         busy <= 1'b0;
      end else if (take) begin
         busy <= 1'b1;
      end else if (!req.stb) begin
         busy <= 1'b0;   // master has let go
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= take && !hit_err;
         err_q <= take && hit_err;
      end
   end

   // data sampled at the select edge, same edge as a mailbox pop
   always_ff @(posedge clk) begin
      if (take) begin
         dat_q <= hit_err ? 32'h0 : rd_dat;
      end
   end

   assign rsp = '{ack: ack_q, err: err_q, dat: dat_q};

endmodule

`default_nettype wire

// ==== verilog/na_conf.sv ====
// *****************************
// read-only tile and system description words plus
// the writable clock domain register with its enable pulse
// read word is combinational, writes land on the select edge
// *****************************
`timescale 1ns/100ps
`default_nettype none

module na_conf #(
   parameter na_pkg::na_config_t CONFIG = na_pkg::na_config_default,
   parameter int TILE_ID   = 0,
   parameter int CORE_BASE = 0
) (
   input  wire logic            clk,
   input  wire logic            rst,
   input  wire logic            sel,         // one cycle per accepted request
   input  wire na_pkg::wb_req_t req,
   output logic [31:0]          dat,
   output logic [2:0]           cdc_conf,
   output logic                 cdc_enable
);
   import na_pkg::*;

   logic [15:0] ct_vec [64];   // indexed by entry as software sees it
   logic [9:0]  idx;
   logic [5:0]  ct_idx;        // addressed entry
   logic [31:0] ct_word;
   logic        cdc_wr;

   assign idx    = req.adr[11:2];
   assign ct_idx = req.adr[6:1];

   // list is presented reversed, entry k is ct_list[num_cts-1-k]
   genvar i;
   generate
      for (i = 0; i < 64; i++) begin : g_ct
         if (i < CONFIG.num_cts) begin : g_used
            assign ct_vec[i] = CONFIG.ct_list[CONFIG.num_cts - 1 - i];
         end else begin : g_unused
            assign ct_vec[i] = 16'h0;   // past the end
         end
      end
   endgenerate

   // even entry in the high half, odd entry in the low half of the word
   assign ct_word = {ct_vec[{ct_idx[5:1], 1'b0}], ct_vec[{ct_idx[5:1], 1'b1}]};

   always_comb begin
      dat = 32'h0;   // holes read zero
      if (req.adr[11:9] == ct_list_base[11:9]) begin
         dat = ct_word;
      end else begin
         case (idx)
            reg_tile_id:      dat = 32'(TILE_ID);
            reg_num_tiles:    dat = 32'(CONFIG.num_tiles);
            reg_conf: begin
               dat[conf_bit_mp]  = CONFIG.enable_mp_simple;
               dat[conf_bit_dma] = CONFIG.enable_dma;
            end
            reg_core_base:    dat = 32'(CORE_BASE);
            reg_domain_cores: dat = 32'(CONFIG.cores_per_tile);
            reg_gmem_size:    dat = CONFIG.gmem_size;
            reg_gmem_tile:    dat = 32'(CONFIG.gmem_tile);
            reg_lmem_size:    dat = CONFIG.lmem_size;
            reg_num_cts:      dat = 32'(CONFIG.num_cts);
            reg_cdc_conf:     dat = 32'(cdc_conf);   // zero-extended
            default:          dat = 32'h0;
         endcase
      end
   end

   // writes elsewhere in the region are acked and dropped
   assign cdc_wr = sel && req.we && (idx == reg_cdc_conf);

   always_ff @(posedge clk) begin
      if (rst) begin
         cdc_conf   <= cdc_conf_default;
         cdc_enable <= 1'b0;
      end else begin
         cdc_enable <= cdc_wr;   // high in the ack cycle only
         if (cdc_wr) begin
            cdc_conf <= req.dat[2:0];
         end
      end
   end

endmodule

`default_nettype wire

// ==== verilog/na_mp_simple.sv ====
// *****************************
// simple mailbox between software and the network
// write to mp_data pushes toward noc_out, read pops from noc_in
// miss flags any access the decoder must answer with err
// *****************************
`timescale 1ns/100ps
`default_nettype none

module na_mp_simple #(
   parameter int DEPTH = 4   // power of two, 2..128
) (
   input  wire logic            clk,
   input  wire logic            rst,
   input  wire logic            sel,
   input  wire na_pkg::wb_req_t req,
   input  wire logic            noc_out_ready,
   input  wire logic            noc_in_valid,
   input  wire logic [31:0]     noc_in_data,
   output logic [31:0]          dat,
   output logic                 miss,
   output logic                 noc_out_valid,
   output logic [31:0]          noc_out_data,
   output logic                 noc_in_ready
);
   import na_pkg::*;

   localparam int aw    = $clog2(DEPTH);
   localparam int cw    = aw + 1;   // count reaches DEPTH
   localparam int q_out = 0;        // toward the network
   localparam int q_in  = 1;        // from the network

   logic [9:0]    idx;
   logic          is_data;
   logic          is_status;
   logic          push  [2];
   logic          pop   [2];
   logic [31:0]   wdata [2];
   logic [31:0]   head  [2];
   logic [cw-1:0] count [2];
   logic          full  [2];
   logic          empty [2];

   // both queues are the same circular buffer
   for (genvar q = 0; q < 2; q++) begin : g_queue
      logic [31:0]   mem [DEPTH];
      logic [aw-1:0] wr_ptr;
      logic [aw-1:0] rd_ptr;
      logic [cw-1:0] cnt;

      always_ff @(posedge clk) begin
         if (push[q]) begin
            mem[wr_ptr] <= wdata[q];
         end
      end

      always_ff @(posedge clk) begin
         if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
         end else begin
            if (push[q]) wr_ptr <= wr_ptr + 1'b1;   // wraps at DEPTH
            if (pop[q])  rd_ptr <= rd_ptr + 1'b1;
            if (push[q] && !pop[q]) begin
               cnt <= cnt + 1'b1;
            end else if (pop[q] && !push[q]) begin
               cnt <= cnt - 1'b1;
            end
         end
      end

      assign head[q]  = mem[rd_ptr];
      assign count[q] = cnt;
      assign full[q]  = (cnt == cw'(DEPTH));
      assign empty[q] = (cnt == '0);
   end

   assign idx       = req.adr[11:2];
   assign is_data   = (idx == mp_data);
   assign is_status = (idx == mp_status);

   // software side
   assign push[q_out]  = sel && req.we && is_data && !full[q_out];
   assign wdata[q_out] = req.dat;
   assign pop[q_in]    = sel && !req.we && is_data && !empty[q_in];

   // network side
   assign pop[q_out]   = noc_out_valid && noc_out_ready;
   assign push[q_in]   = noc_in_valid && noc_in_ready;
   assign wdata[q_in]  = noc_in_data;

   assign noc_out_valid = !empty[q_out];
   assign noc_out_data  = head[q_out];
   assign noc_in_ready  = !full[q_in];

   always_comb begin
      dat = 32'h0;
      if (is_data) begin
         dat = head[q_in];   // popped at the same edge it is registered
      end else if (is_status) begin
         dat[7:0]              = 8'(count[q_in]);
         dat[mp_stat_full_bit] = full[q_out];
      end
   end

   // full push, empty pop, status write, unknown index
   assign miss = (is_data && req.we && full[q_out])
              || (is_data && !req.we && empty[q_in])
              || (is_status && req.we)
              || !(is_data || is_status);

endmodule

`default_nettype wire

// ==== verilog/na_regs_top.sv ====
// *****************************
// network adapter register side of one tile
// bus decoder in front of the config block and the mailbox
// *****************************
`timescale 1ns/100ps
`default_nettype none

module na_regs_top #(
   parameter na_pkg::na_config_t CONFIG = na_pkg::na_config_default,
   parameter int TILE_ID   = 0,
   parameter int CORE_BASE = 0,
   parameter int MP_DEPTH  = 4
) (
   input  wire logic            clk,
   input  wire logic            rst,
   input  wire na_pkg::wb_req_t wb_req,
   output na_pkg::wb_rsp_t      wb_rsp,
   output logic [2:0]           cdc_conf,
   output logic                 cdc_enable,
   output logic                 noc_out_valid,
   output logic [31:0]          noc_out_data,
   input  wire logic            noc_out_ready,
   input  wire logic            noc_in_valid,
   input  wire logic [31:0]     noc_in_data,
   output logic                 noc_in_ready
);
   import na_pkg::*;

   wb_req_t     fwd;        // request as seen by the blocks
   logic        sel_conf;
   logic        sel_mp;
   logic [31:0] conf_dat;
   logic [31:0] mp_dat;
   logic        mp_miss;

   na_bus_decode decode_i (
      .clk      (clk),
      .rst      (rst),
      .req      (wb_req),
      .conf_dat (conf_dat),
      .mp_dat   (mp_dat),
      .mp_miss  (mp_miss),
      .rsp      (wb_rsp),
      .sel_conf (sel_conf),
      .sel_mp   (sel_mp),
      .fwd      (fwd)
   );

   na_conf #(
      .CONFIG    (CONFIG),
      .TILE_ID   (TILE_ID),
      .CORE_BASE (CORE_BASE)
   ) conf_i (
      .clk        (clk),
      .rst        (rst),
      .sel        (sel_conf),
      .req        (fwd),
      .dat        (conf_dat),
      .cdc_conf   (cdc_conf),
      .cdc_enable (cdc_enable)
   );

   na_mp_simple #(
      .DEPTH (MP_DEPTH)
   ) mp_i (
      .clk           (clk),
      .rst           (rst),
      .sel           (sel_mp),
      .req           (fwd),
      .noc_out_ready (noc_out_ready),
      .noc_in_valid  (noc_in_valid),
      .noc_in_data   (noc_in_data),
      .dat           (mp_dat),
      .miss          (mp_miss),
      .noc_out_valid (noc_out_valid),
      .noc_out_data  (noc_out_data),
      .noc_in_ready  (noc_in_ready)
   );

endmodule

`default_nettype wire

// ==== bench/tb_na_regs.sv ====
// *****************************
// testbench of the adapter register side, top is tb_na_regs
// drives the wishbone and noc ports of na_regs_top and checks
// against a reference function and model queues
// *****************************
`timescale 1ns/100ps
`default_nettype none

module tb_na_regs;
   import na_pkg::*;

   localparam int tile_id    = 3;
   localparam int core_base  = 6;
   localparam int wait_limit = 50;          // cycles allowed per wait
   localparam logic [31:0] got_ack = 32'd2; // {ack, err} codes
   localparam logic [31:0] got_err = 32'd1;

   // 5 compute tiles out of 8, entry 0 sits in the low halfword
   localparam na_config_t tb_config = '{
      num_tiles:        16'd8,
      cores_per_tile:   8'd4,
      gmem_size:        32'h0100_0000,
      gmem_tile:        16'd7,
      lmem_size:        32'h0001_0000,
      enable_mp_simple: 1'b1,
      enable_dma:       1'b0,
      num_cts:          7'd5,
      ct_list:          1024'({16'd6, 16'd5, 16'd4, 16'd2, 16'd1})
   };

   logic        clk;
   logic        rst;
   wb_req_t     req;
   wb_rsp_t     wb_rsp;
   logic [2:0]  cdc_conf;
   logic        cdc_enable;
   logic        noc_out_valid;
   logic [31:0] noc_out_data;
   logic        noc_out_ready;
   logic        noc_in_valid;
   logic [31:0] noc_in_data;
   logic        noc_in_ready;

   int          checks = 0;
   int          errors = 0;
   int          err_mark = 0;      // errors when the current test began
   int          pulses = 0;        // cdc_enable cycles seen
   int          pulses_off_ack = 0;
   logic        rsp_ack;
   logic        rsp_err;
   logic [31:0] rsp_dat;
   logic [2:0]  model_cdc;
   logic [31:0] model_out [$];     // words expected on noc_out
   logic [31:0] model_in [$];      // words waiting in the incoming queue
   logic [31:0] out_seen [$];

   na_regs_top #(
      .CONFIG    (tb_config),
      .TILE_ID   (tile_id),
      .CORE_BASE (core_base),
      .MP_DEPTH  (4)
   ) dut_i (
      .clk           (clk),
      .rst           (rst),
      .wb_req        (req),
      .wb_rsp        (wb_rsp),
      .cdc_conf      (cdc_conf),
      .cdc_enable    (cdc_enable),
      .noc_out_valid (noc_out_valid),
      .noc_out_data  (noc_out_data),
      .noc_out_ready (noc_out_ready),
      .noc_in_valid  (noc_in_valid),
      .noc_in_data   (noc_in_data),
      .noc_in_ready  (noc_in_ready)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;   // 8 ns period
   end

   // enable pulse must coincide with ack
   always @(negedge clk) begin
      if (cdc_enable) begin
         pulses++;
         if (!wb_rsp.ack) pulses_off_ack++;
      end
   end

   // values before the edge, i.e. the handshake itself
   always @(posedge clk) begin
      if (!rst && noc_out_valid && noc_out_ready) out_seen.push_back(noc_out_data);
   end

   // entry k of the list as software sees it, reversed order
   function automatic logic [15:0] ct_entry(input int k);
      if (k < int'(tb_config.num_cts)) return tb_config.ct_list[int'(tb_config.num_cts) - 1 - k];
      return 16'h0;
   endfunction

   function automatic logic [31:0] expect_conf(input logic [15:0] adr, input logic [2:0] cdc);
      int base;
      if (adr[11:9] == 3'b001) begin
         base = int'({adr[6:2], 1'b0});   // even entry of the word
         return {ct_entry(base), ct_entry(base + 1)};
      end
      case (adr[11:2])
         10'd0:   return 32'(tile_id);
         10'd1:   return 32'(tb_config.num_tiles);
         10'd3:   return {30'h0, tb_config.enable_dma, tb_config.enable_mp_simple};
         10'd4:   return 32'(core_base);
         10'd6:   return 32'(tb_config.cores_per_tile);
         10'd7:   return tb_config.gmem_size;
         10'd8:   return 32'(tb_config.gmem_tile);
         10'd9:   return tb_config.lmem_size;
         10'd10:  return 32'(tb_config.num_cts);
         10'h042: return {29'h0, cdc};
         default: return 32'h0;
      endcase
   endfunction

   function automatic logic [31:0] resp_code();
      return {30'h0, rsp_ack, rsp_err};
   endfunction

   task automatic check32(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
      end
   endtask

   // one classic cycle, returns at the negedge of the response cycle
   task automatic bus_access(input logic we, input logic [15:0] adr, input logic [31:0] dat);
      int n;
      n = 0;
      @(negedge clk);
      req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
      rsp_ack = 1'b0;
      rsp_err = 1'b0;
      while (!(rsp_ack || rsp_err) && n < wait_limit) begin
         @(negedge clk);
         n++;
         rsp_ack = wb_rsp.ack;
         rsp_err = wb_rsp.err;
         rsp_dat = wb_rsp.dat;
      end
      req = '0;   // stb low for at least one edge
      if (!(rsp_ack || rsp_err)) begin
         errors++;
         $display("timeout: no ack or err for the access at %h", adr);
      end
   endtask

   task automatic wb_read(input logic [15:0] adr);
      bus_access(1'b0, adr, 32'h0);
   endtask

   task automatic wb_write(input logic [15:0] adr, input logic [31:0] dat);
      bus_access(1'b1, adr, dat);
   endtask

   // valid raised only after ready is seen, so it is taken at the next edge
   task automatic noc_send(input logic [31:0] word);
      int n;
      n = 0;
      @(negedge clk);
      while (!noc_in_ready && n < wait_limit) begin
         @(negedge clk);
         n++;
      end
      if (!noc_in_ready) begin
         errors++;
         $display("timeout: noc_in never became ready");
      end else begin
         noc_in_valid = 1'b1;
         noc_in_data  = word;
         @(negedge clk);
         noc_in_valid = 1'b0;
      end
   endtask

   task automatic compare_out();
      int n;
      n = 0;
      while (out_seen.size() < model_out.size() && n < wait_limit) begin
         @(negedge clk);
         n++;
      end
      check32("noc_out word count", 32'(out_seen.size()), 32'(model_out.size()));
      for (int i = 0; i < model_out.size() && i < out_seen.size(); i++) begin
         check32("noc_out word", out_seen[i], model_out[i]);
      end
      out_seen.delete();
      model_out.delete();
   endtask

   task automatic end_test(input int num, input string name);
      $display("test %0d %s: %0d errors", num, name, errors - err_mark);
      err_mark = errors;
   endtask

   initial begin
      logic [15:0] adr;
      int          p0;
      void'($urandom(32'hd798));
      rst           = 1'b1;
      req           = '0;
      noc_out_ready = 1'b0;
      noc_in_valid  = 1'b0;
      noc_in_data   = 32'h0;
      rsp_ack       = 1'b0;
      rsp_err       = 1'b0;
      rsp_dat       = 32'h0;
      model_cdc     = 3'b000;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      check32("response after reset", 32'({wb_rsp.ack, wb_rsp.err, cdc_enable}), 32'h0);
      check32("cdc_conf after reset", 32'(cdc_conf), 32'h0);
      check32("noc_out_valid after reset", 32'(noc_out_valid), 32'h0);
      check32("noc_in_ready after reset", 32'(noc_in_ready), 32'd1);   // incoming empty
      for (int i = 0; i < 20; i++) begin
         adr = (i < 16) ? 16'(i * 4) : 16'((i + 48) * 4);   // 0..15, then 0x40..0x43
         wb_read(adr);
         check32("conf response", resp_code(), got_ack);
         check32($sformatf("conf word at %h", adr), rsp_dat, expect_conf(adr, model_cdc));
      end
      end_test(1, "fixed config registers");

      for (int i = 0; i < 32; i++) begin
         adr = 16'h0200 + 16'(i * 4);
         wb_read(adr);
         check32("ct list response", resp_code(), got_ack);
         check32($sformatf("ct list word at %h", adr), rsp_dat, expect_conf(adr, model_cdc));
      end
      end_test(2, "compute tile list");

      for (int r = 2; r < 16; r++) begin
         wb_read({4'(r), 12'h004});
         check32($sformatf("unmapped read, region %0d", r), resp_code(), got_err);
      end
      wb_write(16'h5000, 32'hdead_beef);
      check32("unmapped write", resp_code(), got_err);
      end_test(3, "unmapped regions");

      p0 = pulses;
      wb_write(16'h0108, 32'hffff_fffd);
      model_cdc = 3'd5;
      check32("cdc write response", resp_code(), got_ack);
      check32("cdc_conf output", 32'(cdc_conf), 32'd5);
      check32("cdc_enable in the ack cycle", 32'(cdc_enable), 32'd1);
      wb_read(16'h0108);
      check32("cdc readback", rsp_dat, expect_conf(16'h0108, model_cdc));
      @(negedge clk);   // monitor has seen every earlier negedge
      check32("cdc_enable cycles for one write and one read", 32'(pulses - p0), 32'd1);
      check32("cdc_enable outside ack", 32'(pulses_off_ack), 32'd0);
      end_test(4, "clock domain register");

      for (int i = 0; i < 4; i++) begin
         model_out.push_back(32'h5a00_0000 + 32'(i));
         wb_write(16'h1000, model_out[i]);
         check32("mailbox write", resp_code(), got_ack);
      end
      wb_write(16'h1000, 32'hffff_0005);
      check32("write to a full queue", resp_code(), got_err);
      wb_read(16'h1004);
      check32("status with outgoing full", rsp_dat, 32'h0000_0100);
      check32("noc_out_valid with words queued", 32'(noc_out_valid), 32'd1);
      @(negedge clk);
      noc_out_ready = 1'b1;
      compare_out();
      end_test(5, "outgoing queue");

      for (int i = 0; i < 4; i++) begin
         model_in.push_back(32'hc0de_0000 + 32'(i));
         noc_send(model_in[i]);
      end
      check32("noc_in_ready with incoming full", 32'(noc_in_ready), 32'd0);
      wb_read(16'h1004);
      check32("status count", rsp_dat, 32'(model_in.size()));
      while (model_in.size() > 0) begin
         wb_read(16'h1000);
         check32("mailbox read", resp_code(), got_ack);
         check32("incoming word", rsp_dat, model_in.pop_front());
      end
      wb_read(16'h1000);
      check32("read from an empty queue", resp_code(), got_err);
      for (int i = 0; i < 60; i++) begin
         case ($urandom % 4)
            0: begin
               adr = 16'($urandom % 32'h280) & 16'hfffc;
               wb_read(adr);
               check32($sformatf("random conf word at %h", adr), rsp_dat,
                       expect_conf(adr, model_cdc));
            end
            1: begin
               model_out.push_back($urandom);
               wb_write(16'h1000, model_out[model_out.size() - 1]);
               check32("random mailbox write", resp_code(), got_ack);
            end
            2: begin
               if (model_in.size() < 4) begin   // queue holds four words
                  model_in.push_back($urandom);
                  noc_send(model_in[model_in.size() - 1]);
               end
            end
            default: begin
               wb_read(16'h1000);
               if (model_in.size() == 0) begin
                  check32("random read when empty", resp_code(), got_err);
               end else begin
                  check32("random mailbox read", resp_code(), got_ack);
                  check32("random incoming word", rsp_dat, model_in.pop_front());
               end
            end
         endcase
      end
      wb_read(16'h1004);
      check32("final status count", rsp_dat, 32'(model_in.size()));
      compare_out();
      end_test(6, "incoming queue and mixed traffic");

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== files.f ====
verilog/na_pkg.sv
verilog/na_bus_decode.sv
verilog/na_conf.sv
verilog/na_mp_simple.sv
verilog/na_regs_top.sv
bench/tb_na_regs.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the adapter register testbench with verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_na_regs -f files.f --Mdir obj_dir -o tb_na_regs
./obj_dir/tb_na_regs | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
   echo "simulation reported failures"
   exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
   echo "simulation ended without a result"
   exit 1
fi
echo "simulation passed"
